// File: Bender.yml
package:
  name: triangles

sources:
  - common/video_pkg.sv
  - common/fb_pkg.sv
  - hw/display_timings.sv
  - draw/draw_line.sv
  - draw/draw_triangle.sv
  - draw/draw_sequencer.sv
  - framebuffer/framebuffer.sv
  - hw/triangles_top.sv
  - target: test
    files:
      - sim/triangles_tb.sv

// File: common/fb_pkg.sv
/* framebuffer package
   geometry, colour widths, palette and the shape table drawn at start-up */

package fb_pkg;

    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_SCALE  = 4;  // each fb pixel is a 4x4 screen block
    localparam int CIDXW     = 4;  // colour index width
    localparam int CHANW     = 4;  // bits per colour channel

    // 12-bit colours, red in the top nibble
    localparam logic [3*CHANW-1:0] PALETTE [16] = '{
        12'h000, 12'h123, 12'h725, 12'h085, 12'hA53, 12'h554, 12'hCCC, 12'hFFE,
        12'hF05, 12'hFA0, 12'hFE2, 12'h0E3, 12'h2AF, 12'h879, 12'hF7A, 12'hFCA
    };

    typedef struct packed {
        logic signed [video_pkg::CORDW-1:0] x0, y0, x1, y1, x2, y2;
        logic [CIDXW-1:0]                   cidx;
    } shape_t;

    localparam int SHAPE_CNT = 3;

    localparam shape_t SHAPE_TABLE [SHAPE_CNT] = '{
        '{30, 10, 140, 40, 80, 82, 4'h9},  // orange
        '{35, 80, 110, 45, 85,  5, 4'hC},  // blue
        '{11, 17,  31, 75, 49, 48, 4'h2}   // dark purple
    };

endpackage

// File: common/video_pkg.sv
/* video timing package
   640x480 60 Hz display timing and screen coordinate width */

package video_pkg;

    localparam int CORDW = 16;  // signed screen coordinate width

    // horizontal timing in pixels
    localparam int H_RES  = 640;
    localparam int H_FP   = 16;
    localparam int H_SYNC = 96;
    localparam int H_BP   = 48;

    // vertical timing in lines
    localparam int V_RES  = 480;
    localparam int V_FP   = 10;
    localparam int V_SYNC = 2;
    localparam int V_BP   = 33;

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800 cycles per line
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525 lines per frame

endpackage

// File: draw/draw_line.sv
/* line rasteriser
   integer Bresenham stepper for all octants, one pixel per cycle */

`timescale 1ns/1ps

module draw_line #(
    parameter int CORDW = 16
) (
    input  logic                    clk_pix,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic signed [CORDW-1:0] x0,
    input  logic signed [CORDW-1:0] y0,
    input  logic signed [CORDW-1:0] x1,
    input  logic signed [CORDW-1:0] y1,
    output logic signed [CORDW-1:0] x,
    output logic signed [CORDW-1:0] y,
    output logic                    drawing,
    output logic                    done
);

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;
    state_t state;

    logic signed [CORDW-1:0] xa, ya, xb, yb;  // endpoints held from start
    logic signed [CORDW:0]   dx, dy, err;     // dy kept negative
    logic signed [CORDW:0]   dx_abs, dy_neg;
    logic signed [CORDW+1:0] e2;
    logic                    right, down;
    logic                    step_x, step_y;

    always_comb begin
        dx_abs = (xb > xa) ? (CORDW+1)'(xb) - (CORDW+1)'(xa) : (CORDW+1)'(xa) - (CORDW+1)'(xb);
        dy_neg = (yb > ya) ? (CORDW+1)'(ya) - (CORDW+1)'(yb) : (CORDW+1)'(yb) - (CORDW+1)'(ya);
        e2     = (CORDW+2)'(err) <<< 1;
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
    end

    always_ff @(posedge clk_pix) begin
        case (state)
            IDLE: if (start) begin
                xa <= x0;
                ya <= y0;
                xb <= x1;
                yb <= y1;
            end
            INIT: begin
                dx    <= dx_abs;
                dy    <= dy_neg;
                err   <= dx_abs + dy_neg;
                right <= (xa < xb);
                down  <= (ya < yb);
                x     <= xa;
                y     <= ya;
            end
            DRAW: if (!(x == xb && y == yb)) begin
                if (step_x) x <= right ? x + CORDW'(1) : x - CORDW'(1);
                if (step_y) y <= down ? y + CORDW'(1) : y - CORDW'(1);
                err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start) state <= INIT;
                INIT:    state <= DRAW;
                DRAW:    if (x == xb && y == yb) state <= DONE;  // last pixel out
                default: state <= IDLE;
            endcase
        end
    end

    assign drawing = (state == DRAW);
    assign done    = (state == DONE);

endmodule

// File: draw/draw_sequencer.sv
/* drawing sequencer
   clears the framebuffer, then draws each shape of the table in order */

`timescale 1ns/1ps

module draw_sequencer #(
    parameter int CORDW  = 16,
    parameter int WIDTH  = 160,
    parameter int HEIGHT = 120
) (
    input  logic                      clk_pix,
    input  logic                      rst_n,
    input  logic                      frame,
    output logic                      we,
    output logic signed [CORDW-1:0]   x,
    output logic signed [CORDW-1:0]   y,
    output logic [fb_pkg::CIDXW-1:0]  cidx,
    output logic                      complete
);

    localparam int SIDW = $clog2(fb_pkg::SHAPE_CNT);

    typedef enum logic [2:0] {IDLE, CLEAR, INIT, DRAW, DONE} state_t;
    state_t state;

    logic [SIDW-1:0]          shape_id;
    logic signed [CORDW-1:0]  cx, cy;  // clear raster position
    logic signed [CORDW-1:0]  vx0, vy0, vx1, vy1, vx2, vy2;
    logic [fb_pkg::CIDXW-1:0] shape_cidx;
    logic                     tri_start, tri_drawing, tri_done;
    logic signed [CORDW-1:0]  tri_x, tri_y;

    // current shape, loaded from the table
    always_ff @(posedge clk_pix) begin
        if (state == INIT) begin
            vx0 <= CORDW'(fb_pkg::SHAPE_TABLE[shape_id].x0);
            vy0 <= CORDW'(fb_pkg::SHAPE_TABLE[shape_id].y0);
            vx1 <= CORDW'(fb_pkg::SHAPE_TABLE[shape_id].x1);
            vy1 <= CORDW'(fb_pkg::SHAPE_TABLE[shape_id].y1);
            vx2 <= CORDW'(fb_pkg::SHAPE_TABLE[shape_id].x2);
            vy2 <= CORDW'(fb_pkg::SHAPE_TABLE[shape_id].y2);
            shape_cidx <= fb_pkg::SHAPE_TABLE[shape_id].cidx;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            shape_id  <= '0;
            cx        <= '0;
            cy        <= '0;
            tri_start <= 1'b0;
        end else begin
            case (state)
                IDLE: if (frame) begin
                    cx    <= '0;
                    cy    <= '0;
                    state <= CLEAR;
                end
                CLEAR: begin
                    if (cx == CORDW'(WIDTH-1)) begin
                        cx <= '0;
                        cy <= cy + CORDW'(1);
                        if (cy == CORDW'(HEIGHT-1)) begin
                            shape_id <= '0;
                            state    <= INIT;
                        end
                    end else begin
                        cx <= cx + CORDW'(1);
                    end
                end
                INIT: begin
                    tri_start <= 1'b1;  // vertices valid next cycle
                    state     <= DRAW;
                end
                DRAW: begin
                    tri_start <= 1'b0;
                    if (tri_done) begin
                        if (shape_id == SIDW'(fb_pkg::SHAPE_CNT-1)) begin
                            state <= DONE;
                        end else begin
                            shape_id <= shape_id + SIDW'(1);
                            state    <= INIT;
                        end
                    end
                end
                default: state <= DONE;  // hold until reset
            endcase
        end
    end

    // write port mux
    always_comb begin
        we       = (state == CLEAR) || (state == DRAW && tri_drawing);
        x        = (state == CLEAR) ? cx : tri_x;
        y        = (state == CLEAR) ? cy : tri_y;
        cidx     = (state == DRAW) ? shape_cidx : '0;  // clear writes black
        complete = (state == DONE);
    end

    draw_triangle #(.CORDW(CORDW)) draw_triangle_inst (
        .clk_pix,
        .rst_n,
        .start(tri_start),
        .x0(vx0),
        .y0(vy0),
        .x1(vx1),
        .y1(vy1),
        .x2(vx2),
        .y2(vy2),
        .x(tri_x),
        .y(tri_y),
        .drawing(tri_drawing),
        .done(tri_done)
    );

endmodule

// File: draw/draw_triangle.sv
/* triangle outline
   draws edges 0-1, 1-2 and 2-0 back to back through one line rasteriser */

`timescale 1ns/1ps

module draw_triangle #(
    parameter int CORDW = 16
) (
    input  logic                    clk_pix,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic signed [CORDW-1:0] x0,
    input  logic signed [CORDW-1:0] y0,
    input  logic signed [CORDW-1:0] x1,
    input  logic signed [CORDW-1:0] y1,
    input  logic signed [CORDW-1:0] x2,
    input  logic signed [CORDW-1:0] y2,
    output logic signed [CORDW-1:0] x,
    output logic signed [CORDW-1:0] y,
    output logic                    drawing,
    output logic                    done
);

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;
    state_t state;

    logic [1:0]              edge_id;  // edge being drawn
    logic signed [CORDW-1:0] vx0, vy0, vx1, vy1, vx2, vy2;
    logic signed [CORDW-1:0] lx0, ly0, lx1, ly1;
    logic                    line_start, line_done;

    // vertices held for the whole triangle
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && start) begin
            {vx0, vy0} <= {x0, y0};
            {vx1, vy1} <= {x1, y1};
            {vx2, vy2} <= {x2, y2};
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            edge_id <= '0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    edge_id <= '0;
                    state   <= INIT;
                end
                INIT: state <= DRAW;
                DRAW: if (line_done) begin
                    if (edge_id == 2'd2) begin
                        state <= DONE;
                    end else begin
                        edge_id <= edge_id + 2'd1;
                        state   <= INIT;  // restart line on next edge
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        case (edge_id)
            2'd0:    {lx0, ly0, lx1, ly1} = {vx0, vy0, vx1, vy1};
            2'd1:    {lx0, ly0, lx1, ly1} = {vx1, vy1, vx2, vy2};
            default: {lx0, ly0, lx1, ly1} = {vx2, vy2, vx0, vy0};
        endcase
        line_start = (state == INIT);
        done       = (state == DONE);
    end

    draw_line #(.CORDW(CORDW)) draw_line_inst (
        .clk_pix,
        .rst_n,
        .start(line_start),
        .x0(lx0),
        .y0(ly0),
        .x1(lx1),
        .y1(ly1),
        .x,
        .y,
        .drawing,
        .done(line_done)
    );

endmodule

// File: framebuffer/framebuffer.sv
/* framebuffer
   colour-index memory with scaled scan read, palette lookup and sync delay */

`timescale 1ns/1ps

module framebuffer #(
    parameter int CORDW  = 16,
    parameter int WIDTH  = 160,
    parameter int HEIGHT = 120,
    parameter int SCALE  = 4
) (
    input  logic                     clk_pix,
    input  logic                     rst_n,
    input  logic                     we,
    input  logic signed [CORDW-1:0]  x,
    input  logic signed [CORDW-1:0]  y,
    input  logic [fb_pkg::CIDXW-1:0] cidx,
    input  logic signed [CORDW-1:0]  sx,
    input  logic signed [CORDW-1:0]  sy,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     de,
    output logic [fb_pkg::CHANW-1:0] red,
    output logic [fb_pkg::CHANW-1:0] green,
    output logic [fb_pkg::CHANW-1:0] blue,
    output logic                     pix_hsync,
    output logic                     pix_vsync,
    output logic                     pix_de
);

    localparam int DEPTH = WIDTH * HEIGHT;
    localparam int ADDRW = $clog2(DEPTH);

    logic [fb_pkg::CIDXW-1:0] mem [DEPTH];
    logic [fb_pkg::CIDXW-1:0] rd_cidx;
    logic [ADDRW-1:0]         wr_addr, rd_addr;
    logic                     wr_ok, rd_ok;
    logic signed [CORDW-1:0]  fx, fy;  // scan position in fb pixels

    always_comb begin
        wr_ok   = we && x >= 0 && x < WIDTH && y >= 0 && y < HEIGHT;  // drop off-screen writes
        wr_addr = ADDRW'(y * WIDTH + x);
        fx      = CORDW'(sx / SCALE);
        fy      = CORDW'(sy / SCALE);
        rd_ok   = fx >= 0 && fx < WIDTH && fy >= 0 && fy < HEIGHT;
        rd_addr = rd_ok ? ADDRW'(fy * WIDTH + fx) : '0;
    end

    always_ff @(posedge clk_pix) begin
        if (wr_ok) mem[wr_addr] <= cidx;
    end

    always_ff @(posedge clk_pix) begin
        rd_cidx <= mem[rd_addr];
    end

    // match syncs to the one-cycle read
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pix_hsync <= 1'b1;
            pix_vsync <= 1'b1;
            pix_de    <= 1'b0;
        end else begin
            pix_hsync <= hsync;
            pix_vsync <= vsync;
            pix_de    <= de;
        end
    end

    // black in blanking
    assign {red, green, blue} = pix_de ? fb_pkg::PALETTE[rd_cidx] : '0;

endmodule

// File: hw/display_timings.sv
/* display timing generator
   scan position, active-low syncs, data enable and frame/line strobes */

`timescale 1ns/1ps

module display_timings #(
    parameter int CORDW = 16
) (
    input  logic                    clk_pix,
    input  logic                    rst_n,
    output logic signed [CORDW-1:0] sx,     // horizontal scan position
    output logic signed [CORDW-1:0] sy,     // vertical scan position
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output logic                    frame,  // start of frame
    output logic                    line    // start of line
);

    localparam logic signed [CORDW-1:0] H_ACT  = CORDW'(video_pkg::H_RES);
    localparam logic signed [CORDW-1:0] V_ACT  = CORDW'(video_pkg::V_RES);
    localparam logic signed [CORDW-1:0] H_END  = CORDW'(video_pkg::H_TOTAL - 1);
    localparam logic signed [CORDW-1:0] V_END  = CORDW'(video_pkg::V_TOTAL - 1);
    localparam logic signed [CORDW-1:0] HS_STA = CORDW'(video_pkg::H_RES + video_pkg::H_FP);
    localparam logic signed [CORDW-1:0] HS_END = CORDW'(video_pkg::H_RES + video_pkg::H_FP
                                                        + video_pkg::H_SYNC);
    localparam logic signed [CORDW-1:0] VS_STA = CORDW'(video_pkg::V_RES + video_pkg::V_FP);
    localparam logic signed [CORDW-1:0] VS_END = CORDW'(video_pkg::V_RES + video_pkg::V_FP
                                                        + video_pkg::V_SYNC);

    // scan counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_END) begin
            sx <= '0;
            sy <= (sy == V_END) ? '0 : sy + CORDW'(1);  // wrap at end of frame
        end else begin
            sx <= sx + CORDW'(1);
        end
    end

    always_comb begin
        hsync = !(sx >= HS_STA && sx < HS_END);  // active low
        vsync = !(sy >= VS_STA && sy < VS_END);  // active low
        de    = (sx < H_ACT) && (sy < V_ACT);
        frame = (sx == '0) && (sy == '0);
        line  = (sx == '0);
    end

endmodule

// File: hw/triangles_top.sv
/* triangles top level
   display timing, drawing engine and framebuffer for 640x480 video */

`timescale 1ns/1ps

module triangles_top (
    input  logic                     clk_pix,
    input  logic                     rst_n,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de,
    output logic [fb_pkg::CHANW-1:0] red,
    output logic [fb_pkg::CHANW-1:0] green,
    output logic [fb_pkg::CHANW-1:0] blue,
    output logic                     complete
);

    logic signed [video_pkg::CORDW-1:0] sx, sy;
    logic                               tim_hsync, tim_vsync, tim_de, frame;
    logic                               fb_we;
    logic signed [video_pkg::CORDW-1:0] fb_x, fb_y;
    logic [fb_pkg::CIDXW-1:0]           fb_cidx;

    display_timings #(.CORDW(video_pkg::CORDW)) display_timings_inst (
        .clk_pix,
        .rst_n,
        .sx,
        .sy,
        .hsync(tim_hsync),
        .vsync(tim_vsync),
        .de(tim_de),
        .frame,
        .line()
    );

    draw_sequencer #(
        .CORDW(video_pkg::CORDW),
        .WIDTH(fb_pkg::FB_WIDTH),
        .HEIGHT(fb_pkg::FB_HEIGHT)
    ) draw_sequencer_inst (
        .clk_pix,
        .rst_n,
        .frame,
        .we(fb_we),
        .x(fb_x),
        .y(fb_y),
        .cidx(fb_cidx),
        .complete
    );

    framebuffer #(
        .CORDW(video_pkg::CORDW),
        .WIDTH(fb_pkg::FB_WIDTH),
        .HEIGHT(fb_pkg::FB_HEIGHT),
        .SCALE(fb_pkg::FB_SCALE)
    ) framebuffer_inst (
        .clk_pix,
        .rst_n,
        .we(fb_we),
        .x(fb_x),
        .y(fb_y),
        .cidx(fb_cidx),
        .sx,
        .sy,
        .hsync(tim_hsync),
        .vsync(tim_vsync),
        .de(tim_de),
        .red,
        .green,
        .blue,
        .pix_hsync(hsync),
        .pix_vsync(vsync),
        .pix_de(de)
    );

endmodule

// File: sim/triangles_tb.sv
/* triangles testbench
   checks syncs, blanking, completion and drawn colours over three frames */

`timescale 1ns/1ps

module triangles_tb;

    localparam int LINE_CYC  = video_pkg::H_TOTAL;
    localparam int FRAME_CYC = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    localparam int FB_W      = fb_pkg::FB_WIDTH;
    localparam int FB_H      = fb_pkg::FB_HEIGHT;
    localparam int N_SAMPLES = 8;

    logic                     clk_pix;
    logic                     rst_n;
    logic                     hsync, vsync, de, complete;
    logic [fb_pkg::CHANW-1:0] red, green, blue;

    int   timing_errs, colour_errs, other_errs;
    int   expect_map [FB_W*FB_H];  // -1 means not checked
    int   vertex_checks, black_checks, frames_seen;
    int   cyc, h_fall, v_fall, de_rise, col, row, de_lines;
    logic live = 1'b0;  // reset seen released at a rising edge
    logic prev_h, prev_v, prev_de, checking, seen_complete;

    triangles_top triangles_top_inst (
        .clk_pix,
        .rst_n,
        .hsync,
        .vsync,
        .de,
        .red,
        .green,
        .blue,
        .complete
    );

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) live <= rst_n;

    // colour must be black outside active video
    assert property (@(posedge clk_pix) disable iff (!rst_n)
        !de |-> (red == '0 && green == '0 && blue == '0))
    else begin
        colour_errs++;
        $display("** Error: {red,green,blue} in blanking = 0x%03h, expected 0x000",
                 $sampled({red, green, blue}));
    end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            timing_errs++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_reset_state(input logic in_reset);
        assert (!complete) else begin
            other_errs++;
            $display("** Error: complete = 0x%0h, expected 0x0", complete);
        end
        assert (hsync && vsync) else begin
            other_errs++;
            $display("** Error: {hsync,vsync} = 0x%0h, expected 0x3", {hsync, vsync});
        end
        assert (!(in_reset && de)) else begin
            other_errs++;
            $display("** Error: de = 0x%0h, expected 0x0", de);
        end
    endtask

    function automatic logic near_shape(input int px, input int py);
        fb_pkg::shape_t s;
        int             lo_x, hi_x, lo_y, hi_y;
        for (int i = 0; i < fb_pkg::SHAPE_CNT; i++) begin
            s    = fb_pkg::SHAPE_TABLE[i];
            lo_x = s.x0 < s.x1 ? (s.x0 < s.x2 ? s.x0 : s.x2) : (s.x1 < s.x2 ? s.x1 : s.x2);
            hi_x = s.x0 > s.x1 ? (s.x0 > s.x2 ? s.x0 : s.x2) : (s.x1 > s.x2 ? s.x1 : s.x2);
            lo_y = s.y0 < s.y1 ? (s.y0 < s.y2 ? s.y0 : s.y2) : (s.y1 < s.y2 ? s.y1 : s.y2);
            hi_y = s.y0 > s.y1 ? (s.y0 > s.y2 ? s.y0 : s.y2) : (s.y1 > s.y2 ? s.y1 : s.y2);
            if (px >= lo_x - 3 && px <= hi_x + 3 && py >= lo_y - 3 && py <= hi_y + 3)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic build_expect_map();
        fb_pkg::shape_t s;
        int             px, py, placed, tries;
        for (int i = 0; i < FB_W*FB_H; i++) expect_map[i] = -1;
        // later shapes win, as in draw order; no vertex lies on a later outline
        for (int i = 0; i < fb_pkg::SHAPE_CNT; i++) begin
            s = fb_pkg::SHAPE_TABLE[i];
            expect_map[s.y0*FB_W + s.x0] = int'(fb_pkg::PALETTE[s.cidx]);
            expect_map[s.y1*FB_W + s.x1] = int'(fb_pkg::PALETTE[s.cidx]);
            expect_map[s.y2*FB_W + s.x2] = int'(fb_pkg::PALETTE[s.cidx]);
        end
        placed = 0;
        tries  = 0;
        while (placed < N_SAMPLES && tries < 1000) begin
            tries++;
            px = $urandom_range(FB_W-1);
            py = $urandom_range(FB_H-1);
            if (!near_shape(px, py) && expect_map[py*FB_W + px] < 0) begin
                expect_map[py*FB_W + px] = 0;  // background stays black
                placed++;
            end
        end
        if (placed < N_SAMPLES) begin
            other_errs++;
            $display("could not place all background samples away from the shapes");
        end
    endtask

    task automatic check_pixel(input int px, input int py);
        int idx;
        idx = (py / fb_pkg::FB_SCALE) * FB_W + px / fb_pkg::FB_SCALE;
        if (expect_map[idx] >= 0) begin
            if (expect_map[idx] == 0) black_checks++;
            else vertex_checks++;
            assert ({red, green, blue} == 12'(expect_map[idx])) else begin
                colour_errs++;
                $display("** Error: {red,green,blue} at (%0d,%0d) = 0x%03h, expected 0x%03h",
                         px, py, {red, green, blue}, 12'(expect_map[idx]));
            end
        end
    endtask

    // scan position is rebuilt from the de and sync edges seen on the outputs
    always @(negedge clk_pix) begin
        if (live) begin
            cyc++;
            if (prev_h && !hsync) begin
                if (h_fall >= 0) check_value("hsync period", cyc - h_fall, LINE_CYC);
                h_fall = cyc;
            end
            if (!prev_h && hsync && h_fall >= 0)
                check_value("hsync low", cyc - h_fall, video_pkg::H_SYNC);
            if (prev_v && !vsync) begin
                if (v_fall >= 0) check_value("vsync period", cyc - v_fall, FRAME_CYC);
                check_value("de lines", de_lines, video_pkg::V_RES);
                v_fall   = cyc;
                de_lines = 0;
                row      = 0;
                frames_seen++;
                if (seen_complete) checking = 1'b1;
            end
            if (!prev_v && vsync && v_fall >= 0)
                check_value("vsync low", cyc - v_fall, video_pkg::V_SYNC * LINE_CYC);
            if (de) begin
                if (!prev_de) begin
                    col     = 0;
                    de_rise = cyc;
                end else begin
                    col++;
                end
                if (checking) check_pixel(col, row);
            end else if (prev_de) begin
                check_value("de high", cyc - de_rise, video_pkg::H_RES);
                row++;
                de_lines++;
            end
            assert (complete || !seen_complete) else begin
                other_errs++;
                $display("complete dropped after it had risen");
            end
            if (complete) seen_complete = 1'b1;
            prev_h  = hsync;
            prev_v  = vsync;
            prev_de = de;
        end
    end

    initial begin
        int wait_cyc;
        {timing_errs, colour_errs, other_errs} = '0;
        {vertex_checks, black_checks, frames_seen, cyc, col, row, de_lines} = '0;
        h_fall  = -1;
        v_fall  = -1;
        de_rise = -1;
        {prev_h, prev_v, prev_de, checking, seen_complete} = 5'b11000;
        void'($urandom(9));
        rst_n    = 1'b0;
        build_expect_map();
        repeat (8) begin
            @(negedge clk_pix);
            check_reset_state(1'b1);
        end
        rst_n = 1'b1;
        @(negedge clk_pix);
        check_reset_state(1'b0);

        wait_cyc = 0;
        while (!complete && wait_cyc < 2*FRAME_CYC) begin
            @(negedge clk_pix);
            wait_cyc++;
        end
        if (!complete) begin
            other_errs++;
            $display("complete did not rise within two frames of reset");
        end

        wait_cyc = 0;
        while (frames_seen < 3 && wait_cyc < 4*FRAME_CYC) begin
            @(posedge clk_pix);
            wait_cyc++;
        end
        if (frames_seen < 3) begin
            other_errs++;
            $display("three frames did not go by before the timeout");
        end
        if (vertex_checks < 9 * 16 || black_checks < N_SAMPLES * 16) begin
            other_errs++;
            $display("too few pixels checked, vertex %0d, background %0d",
                     vertex_checks, black_checks);
        end

        $display("errors: timing %0d, colour %0d, other %0d",
                 timing_errs, colour_errs, other_errs);
        if (timing_errs + colour_errs + other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: triangles.f
common/video_pkg.sv
common/fb_pkg.sv
hw/display_timings.sv
draw/draw_line.sv
draw/draw_triangle.sv
draw/draw_sequencer.sv
framebuffer/framebuffer.sv
hw/triangles_top.sv
sim/triangles_tb.sv
